// File: logic/isaPkg.sv
`default_nettype none

package isaPkg;

	// Word and field widths of the 16-bit ISA
	localparam int INSTR_WIDTH = 16;
	localparam int ADDR_WIDTH = 16;
	localparam int DATA_WIDTH = 16;
	localparam int OPCODE_WIDTH = 4;
	localparam int REG_INDEX_WIDTH = 4;
	localparam int COND_WIDTH = 3;

	// One instruction as read from instruction memory
	typedef logic [INSTR_WIDTH-1:0] instrWord;

	// Word address into instruction memory
	typedef logic [ADDR_WIDTH-1:0] pcAddr;

	// Register number, sixteen registers
	typedef logic [REG_INDEX_WIDTH-1:0] regIndex;

	// Immediate value or data word
	typedef logic [DATA_WIDTH-1:0] dataWord;

	// Branch condition code from instr[11:9]
	typedef logic [COND_WIDTH-1:0] branchCond;

	// Opcode in instr[15:12]
	// 0xxx is arithmetic and shift, 10xx is memory and byte load
	// 11xx is control flow
	typedef enum logic [OPCODE_WIDTH-1:0] {
		ADD = 4'd0, SUB, RED, XOR, SLL, SRA, ROR, PADDSB,
		LW = 4'd8, SW, LHB, LLB,
		B = 4'd12, BR, PCS, HLT = 4'd15
	} opcode;

endpackage

`default_nettype wire

// File: logic/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

	// Widths of the encoded control selects
	localparam int DATA_SEL_WIDTH = 2;
	localparam int IMM_SEL_WIDTH = 3;

	// Source of the register write data
	// ALU result for arithmetic, shifts and byte loads
	// Memory read data for LW
	// Return address for PCS
	typedef enum logic [DATA_SEL_WIDTH-1:0] {
		DATA_ALU = 2'd0,
		DATA_MEM,
		DATA_PC
	} dataSrcSel;

	// Immediate formats
	// IMM_SHIFT4 zero-extends instr[3:0] for the shift amount
	// IMM_OFFSET4 sign-extends instr[3:0] for the LW/SW offset
	// IMM_LOW8 zero-extends instr[7:0] for LLB
	// IMM_HIGH8 puts instr[7:0] in the upper byte for LHB
	// IMM_BRANCH9 sign-extends instr[8:0] for B
	typedef enum logic [IMM_SEL_WIDTH-1:0] {
		IMM_NONE = 3'd0,
		IMM_SHIFT4,
		IMM_OFFSET4,
		IMM_LOW8,
		IMM_HIGH8,
		IMM_BRANCH9
	} immFormat;

	// First fetch address after reset
	localparam isaPkg::pcAddr RESET_PC = '0;

endpackage

`default_nettype wire

// File: logic/fetchDecodeIf.sv
`timescale 1ns/1ps
`default_nettype none

// One fetched instruction on its way down the front end
interface fetchDecodeIf;

	// Word is real and may be decoded
	logic valid;
	// Address the word came from
	isaPkg::pcAddr pc;
	// Raw instruction word
	isaPkg::instrWord instr;

	// Side that drives the instruction
	modport producer (
		output valid,
		output pc,
		output instr
	);

	// Side that takes the instruction
	modport consumer (
		input valid,
		input pc,
		input instr
	);

endinterface

`default_nettype wire

// File: logic/instrFetch.sv
`timescale 1ns/1ps
`default_nettype none

module instrFetch (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic halted,
	input logic redirect,
	input isaPkg::pcAddr redirectPc,
	input isaPkg::instrWord instrData,
	output isaPkg::pcAddr instrAddr,
	fetchDecodeIf.producer fetchOut
);

	// Program counter
	isaPkg::pcAddr pc;
	// Address of the next sequential word
	isaPkg::pcAddr pcNext;
	// PC stays put this cycle
	logic pcHold;

	assign pcNext = pc + isaPkg::pcAddr'(1);

	// Halt freezes fetch just like a stall
	assign pcHold = stall || halted;

	// PC update
	// Redirect wins over stall and halt so a halted core can be released
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= ctrlPkg::RESET_PC;
		end else if (redirect) begin
			pc <= redirectPc;
		end else if (!pcHold) begin
			pc <= pcNext;
		end
	end

	// Instruction memory is read combinationally at the PC
	assign instrAddr = pc;

	// Word returned this cycle goes straight to the buffer
	assign fetchOut.pc = pc;
	assign fetchOut.instr = instrData;

	// Word fetched in a redirect cycle is on the wrong path
	// Nothing new is fetched while halted
	assign fetchOut.valid = !halted && !redirect;

endmodule

`default_nettype wire

// File: logic/fetchDecodeBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module fetchDecodeBuffer (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic redirect,
	input logic halted,
	fetchDecodeIf.consumer bufIn,
	fetchDecodeIf.producer bufOut
);

	// Held instruction
	logic validQ;
	isaPkg::pcAddr pcQ;
	isaPkg::instrWord instrQ;

	// Buffer already holds a valid HLT
	logic holdingHlt;
	// HLT has to stay in place while the core is halted
	logic keepHlt;
	// New word is taken at this edge
	logic capture;

	assign holdingHlt = validQ && (isaPkg::opcode'(instrQ[15:12]) == isaPkg::HLT);
	assign keepHlt = halted && holdingHlt;
	assign capture = !stall && !keepHlt;

	// Valid bit
	// Redirect kills the slot regardless of stall
	// Halt lets in nothing new
	always_ff @(posedge clk) begin
		if (reset) begin
			validQ <= 1'b0;
		end else if (redirect) begin
			validQ <= 1'b0;
		end else if (capture) begin
			validQ <= bufIn.valid && !halted;
		end
	end

	// Payload only moves with a capture
	// Contents behind a cleared valid are ignored downstream
	always_ff @(posedge clk) begin
		if (capture) begin
			pcQ <= bufIn.pc;
			instrQ <= bufIn.instr;
		end
	end

	assign bufOut.valid = validQ;
	assign bufOut.pc = pcQ;
	assign bufOut.instr = instrQ;

endmodule

`default_nettype wire

// File: logic/controlDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module controlDecoder (
	input isaPkg::opcode op,
	output logic regSrc,
	output logic regWrite,
	output logic memEnable,
	output logic memWrite,
	output logic aluSrcImm,
	output logic branch,
	output logic branchSrc,
	output ctrlPkg::dataSrcSel dataSrc,
	output ctrlPkg::immFormat immSel
);

	always_comb begin
		// Defaults describe a no-op
		regSrc = 1'b0;
		regWrite = 1'b0;
		memEnable = 1'b0;
		memWrite = 1'b0;
		aluSrcImm = 1'b0;
		branch = 1'b0;
		branchSrc = 1'b0;
		dataSrc = ctrlPkg::DATA_ALU;
		immSel = ctrlPkg::IMM_NONE;

		case (op)
			// Register to register arithmetic
			isaPkg::ADD, isaPkg::SUB, isaPkg::RED, isaPkg::XOR, isaPkg::PADDSB: begin
				regWrite = 1'b1;
			end
			// Shift amount comes from instr[3:0]
			isaPkg::SLL, isaPkg::SRA, isaPkg::ROR: begin
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
				immSel = ctrlPkg::IMM_SHIFT4;
			end
			// Load word, address is rs plus offset
			isaPkg::LW: begin
				regWrite = 1'b1;
				memEnable = 1'b1;
				aluSrcImm = 1'b1;
				dataSrc = ctrlPkg::DATA_MEM;
				immSel = ctrlPkg::IMM_OFFSET4;
			end
			// Store word reads rt from instr[11:8]
			isaPkg::SW: begin
				regSrc = 1'b1;
				memEnable = 1'b1;
				memWrite = 1'b1;
				aluSrcImm = 1'b1;
				immSel = ctrlPkg::IMM_OFFSET4;
			end
			// Byte loads merge into the old value of rd
			isaPkg::LHB: begin
				regSrc = 1'b1;
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
				immSel = ctrlPkg::IMM_HIGH8;
			end
			isaPkg::LLB: begin
				regSrc = 1'b1;
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
				immSel = ctrlPkg::IMM_LOW8;
			end
			// Branch to PC-relative immediate
			isaPkg::B: begin
				branch = 1'b1;
				immSel = ctrlPkg::IMM_BRANCH9;
			end
			// Branch to register
			isaPkg::BR: begin
				branch = 1'b1;
				branchSrc = 1'b1;
			end
			// Save return address in rd
			isaPkg::PCS: begin
				regWrite = 1'b1;
				dataSrc = ctrlPkg::DATA_PC;
			end
			// HLT drives no control, decode flags it separately
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: logic/instrDecode.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecode (
	fetchDecodeIf.consumer decIn,
	output logic decValid,
	output isaPkg::pcAddr decPc,
	output isaPkg::regIndex readReg1,
	output isaPkg::regIndex readReg2,
	output isaPkg::regIndex writeReg,
	output isaPkg::dataWord immValue,
	output isaPkg::branchCond cond,
	output logic regWrite,
	output logic memEnable,
	output logic memWrite,
	output logic aluSrcImm,
	output logic branch,
	output logic branchSrc,
	output logic halted,
	output ctrlPkg::dataSrcSel dataSrc
);

	// Opcode field
	isaPkg::opcode op;

	// Raw decoder outputs before the valid gate
	logic regSrc;
	logic rawRegWrite;
	logic rawMemEnable;
	logic rawMemWrite;
	logic rawAluSrcImm;
	logic rawBranch;
	logic rawBranchSrc;
	ctrlPkg::dataSrcSel rawDataSrc;
	ctrlPkg::immFormat immSel;

	assign op = isaPkg::opcode'(decIn.instr[15:12]);

	controlDecoder ctrl (
		.op(op),
		.regSrc(regSrc),
		.regWrite(rawRegWrite),
		.memEnable(rawMemEnable),
		.memWrite(rawMemWrite),
		.aluSrcImm(rawAluSrcImm),
		.branch(rawBranch),
		.branchSrc(rawBranchSrc),
		.dataSrc(rawDataSrc),
		.immSel(immSel)
	);

	assign decValid = decIn.valid;
	assign decPc = decIn.pc;

	// rs always sits in slot 2
	assign readReg1 = decIn.instr[7:4];
	// rd sits in slot 1
	assign writeReg = decIn.instr[11:8];
	// SW and the byte loads read the register in slot 1
	assign readReg2 = regSrc ? decIn.instr[11:8] : decIn.instr[3:0];

	assign cond = decIn.instr[11:9];

	// Immediate generation
	always_comb begin
		case (immSel)
			ctrlPkg::IMM_SHIFT4: immValue = isaPkg::dataWord'(decIn.instr[3:0]);
			ctrlPkg::IMM_OFFSET4: immValue = {{12{decIn.instr[3]}}, decIn.instr[3:0]};
			ctrlPkg::IMM_LOW8: immValue = isaPkg::dataWord'(decIn.instr[7:0]);
			ctrlPkg::IMM_HIGH8: immValue = {decIn.instr[7:0], 8'h00};
			ctrlPkg::IMM_BRANCH9: immValue = {{7{decIn.instr[8]}}, decIn.instr[8:0]};
			default: immValue = '0;
		endcase
	end

	// A bubble must not write, access memory or branch
	assign regWrite = decIn.valid && rawRegWrite;
	assign memEnable = decIn.valid && rawMemEnable;
	assign memWrite = decIn.valid && rawMemWrite;
	assign aluSrcImm = decIn.valid && rawAluSrcImm;
	assign branch = decIn.valid && rawBranch;
	assign branchSrc = decIn.valid && rawBranchSrc;
	assign dataSrc = decIn.valid ? rawDataSrc : ctrlPkg::DATA_ALU;

	// Halt is a valid HLT in the decode slot
	assign halted = decIn.valid && (op == isaPkg::HLT);

endmodule

`default_nettype wire

// File: logic/decodeFrontEnd.sv
`timescale 1ns/1ps
`default_nettype none

module decodeFrontEnd (
	input logic clk,
	input logic reset,
	input isaPkg::instrWord instrData,
	input logic stall,
	input logic redirect,
	input isaPkg::pcAddr redirectPc,
	output isaPkg::pcAddr instrAddr,
	output logic decValid,
	output isaPkg::pcAddr decPc,
	output isaPkg::regIndex readReg1,
	output isaPkg::regIndex readReg2,
	output isaPkg::regIndex writeReg,
	output isaPkg::dataWord immValue,
	output isaPkg::branchCond cond,
	output logic regWrite,
	output logic memEnable,
	output logic memWrite,
	output logic aluSrcImm,
	output ctrlPkg::dataSrcSel dataSrc,
	output logic branch,
	output logic branchSrc,
	output logic halted
);

	// Fetch to IF/ID buffer
	fetchDecodeIf fetchLink ();
	// IF/ID buffer to decode
	fetchDecodeIf decodeLink ();

	// halted is produced by decode and freezes fetch and the buffer
	instrFetch fetch (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.halted(halted),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.instrData(instrData),
		.instrAddr(instrAddr),
		.fetchOut(fetchLink)
	);

	fetchDecodeBuffer ifId (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.redirect(redirect),
		.halted(halted),
		.bufIn(fetchLink),
		.bufOut(decodeLink)
	);

	instrDecode decode (
		.decIn(decodeLink),
		.decValid(decValid),
		.decPc(decPc),
		.readReg1(readReg1),
		.readReg2(readReg2),
		.writeReg(writeReg),
		.immValue(immValue),
		.cond(cond),
		.regWrite(regWrite),
		.memEnable(memEnable),
		.memWrite(memWrite),
		.aluSrcImm(aluSrcImm),
		.branch(branch),
		.branchSrc(branchSrc),
		.halted(halted),
		.dataSrc(dataSrc)
	);

endmodule

`default_nettype wire

// File: testbench/frontEndVectors.svh
`ifndef FRONT_END_VECTORS_SVH
`define FRONT_END_VECTORS_SVH

// Columns: address, word, readReg1, readReg2, writeReg, immValue, cond,
// ctrlBits {regWrite, memEnable, memWrite, aluSrcImm, branch, branchSrc}, dataSrc, halted, action

// Step after a row is checked
// JUMP redirects to the next row's address
// HALT_JUMP watches the halt first, then redirects
typedef enum logic [1:0] {
	STEP,
	JUMP,
	HALT_JUMP
} rowAction;

// One expected decode
typedef struct packed {
	isaPkg::pcAddr addr;
	isaPkg::instrWord word;
	isaPkg::regIndex readReg1;
	isaPkg::regIndex readReg2;
	isaPkg::regIndex writeReg;
	isaPkg::dataWord imm;
	isaPkg::branchCond cond;
	logic [5:0] ctrlBits;
	ctrlPkg::dataSrcSel dataSrc;
	logic halted;
	rowAction action;
} vecRow;

localparam int NUM_ROWS = 18;

// Rows in the order the decode stage must show them
localparam vecRow VECTORS [NUM_ROWS] = '{
	// ADD, SUB, RED, XOR
	'{16'h0000, 16'h0123, 4'h2, 4'h3, 4'h1, 16'h0000, 3'd0, 6'b100000, ctrlPkg::DATA_ALU, 1'b0, STEP},
	'{16'h0001, 16'h1456, 4'h5, 4'h6, 4'h4, 16'h0000, 3'd2, 6'b100000, ctrlPkg::DATA_ALU, 1'b0, STEP},
	'{16'h0002, 16'h2789, 4'h8, 4'h9, 4'h7, 16'h0000, 3'd3, 6'b100000, ctrlPkg::DATA_ALU, 1'b0, STEP},
	'{16'h0003, 16'h3abc, 4'hb, 4'hc, 4'ha, 16'h0000, 3'd5, 6'b100000, ctrlPkg::DATA_ALU, 1'b0, STEP},
	// Shifts with a zero-extended amount, then PADDSB
	'{16'h0004, 16'h4de5, 4'he, 4'h5, 4'hd, 16'h0005, 3'd6, 6'b100100, ctrlPkg::DATA_ALU, 1'b0, STEP},
	'{16'h0005, 16'h5f0a, 4'h0, 4'ha, 4'hf, 16'h000a, 3'd7, 6'b100100, ctrlPkg::DATA_ALU, 1'b0, STEP},
	'{16'h0006, 16'h621f, 4'h1, 4'hf, 4'h2, 16'h000f, 3'd1, 6'b100100, ctrlPkg::DATA_ALU, 1'b0, STEP},
	'{16'h0007, 16'h7345, 4'h4, 4'h5, 4'h3, 16'h0000, 3'd1, 6'b100000, ctrlPkg::DATA_ALU, 1'b0, STEP},
	// LW with negative offset, SW, LHB, LLB
	'{16'h0008, 16'h867c, 4'h7, 4'hc, 4'h6, 16'hfffc, 3'd3, 6'b110100, ctrlPkg::DATA_MEM, 1'b0, STEP},
	'{16'h0009, 16'h9893, 4'h9, 4'h8, 4'h8, 16'h0003, 3'd4, 6'b011100, ctrlPkg::DATA_ALU, 1'b0, STEP},
	'{16'h000a, 16'ha5c3, 4'hc, 4'h5, 4'h5, 16'hc300, 3'd2, 6'b100100, ctrlPkg::DATA_ALU, 1'b0, STEP},
	'{16'h000b, 16'hb4f7, 4'hf, 4'h4, 4'h4, 16'h00f7, 3'd2, 6'b100100, ctrlPkg::DATA_ALU, 1'b0, STEP},
	// Taken B and BR, each followed by a redirect
	'{16'h000c, 16'hc781, 4'h8, 4'h1, 4'h7, 16'hff81, 3'd3, 6'b000010, ctrlPkg::DATA_ALU, 1'b0, JUMP},
	'{16'h0040, 16'hd450, 4'h5, 4'h0, 4'h4, 16'h0000, 3'd2, 6'b000011, ctrlPkg::DATA_ALU, 1'b0, JUMP},
	// PCS then HLT
	'{16'h0080, 16'he900, 4'h0, 4'h0, 4'h9, 16'h0000, 3'd4, 6'b100000, ctrlPkg::DATA_PC, 1'b0, STEP},
	'{16'h0081, 16'hf000, 4'h0, 4'h0, 4'h0, 16'h0000, 3'd0, 6'b000000, ctrlPkg::DATA_ALU, 1'b1,
		HALT_JUMP},
	// Resumed after the halt
	'{16'h0020, 16'h8ab5, 4'hb, 4'h5, 4'ha, 16'h0005, 3'd5, 6'b110100, ctrlPkg::DATA_MEM, 1'b0, STEP},
	'{16'h0021, 16'h0fed, 4'he, 4'hd, 4'hf, 16'h0000, 3'd7, 6'b100000, ctrlPkg::DATA_ALU, 1'b0, STEP}
};

`endif

// File: testbench/frontEndTb.sv
`timescale 1ns/1ps
`default_nettype none

module frontEndTb;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 3;
	localparam int CYCLES_PER_ROW = 40;
	localparam int HALT_HOLD_CYCLES = 10;
	localparam logic [31:0] LFSR_SEED = 32'h34fc_0214;
	// Background contents of instruction memory
	localparam isaPkg::instrWord FILL_MASK = 16'h5a3c;

	`include "frontEndVectors.svh"

	logic clk;
	logic reset;
	logic stall;
	logic redirect;
	isaPkg::pcAddr redirectPc;
	isaPkg::instrWord instrData;
	isaPkg::pcAddr instrAddr;
	logic decValid;
	isaPkg::pcAddr decPc;
	isaPkg::regIndex readReg1;
	isaPkg::regIndex readReg2;
	isaPkg::regIndex writeReg;
	isaPkg::dataWord immValue;
	isaPkg::branchCond cond;
	logic regWrite;
	logic memEnable;
	logic memWrite;
	logic aluSrcImm;
	ctrlPkg::dataSrcSel dataSrc;
	logic branch;
	logic branchSrc;
	logic halted;

	// Full 64K word instruction memory
	isaPkg::instrWord imem [0:65535];
	logic [31:0] lfsrState;

	decodeFrontEnd DUT (
		.clk(clk),
		.reset(reset),
		.instrData(instrData),
		.stall(stall),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.instrAddr(instrAddr),
		.decValid(decValid),
		.decPc(decPc),
		.readReg1(readReg1),
		.readReg2(readReg2),
		.writeReg(writeReg),
		.immValue(immValue),
		.cond(cond),
		.regWrite(regWrite),
		.memEnable(memEnable),
		.memWrite(memWrite),
		.aluSrcImm(aluSrcImm),
		.dataSrc(dataSrc),
		.branch(branch),
		.branchSrc(branchSrc),
		.halted(halted)
	);

	// Combinational read, word returns in the same cycle
	assign instrData = imem[instrAddr];

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Whole table must finish within its cycle budget
	initial begin
		#(NUM_ROWS * CYCLES_PER_ROW * CLK_PERIOD);
		$display("Timeout: decode did not reach the end of the table in %0d cycles",
			NUM_ROWS * CYCLES_PER_ROW);
		abortRun();
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		lfsrNext = {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic abortRun();
		$display("Test failures found");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic checkFlag(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, expected);
			abortRun();
		end
	endtask

	task automatic checkIndex(input string name, input isaPkg::regIndex got,
		input isaPkg::regIndex expected);
		if (got !== expected) begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, expected);
			abortRun();
		end
	endtask

	task automatic checkWord(input string name, input isaPkg::dataWord got,
		input isaPkg::dataWord expected);
		if (got !== expected) begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, expected);
			abortRun();
		end
	endtask

	task automatic checkPc(input string name, input isaPkg::pcAddr got,
		input isaPkg::pcAddr expected);
		if (got !== expected) begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, expected);
			abortRun();
		end
	endtask

	task automatic checkCond(input string name, input isaPkg::branchCond got,
		input isaPkg::branchCond expected);
		if (got !== expected) begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, expected);
			abortRun();
		end
	endtask

	task automatic checkDataSrc(input string name, input ctrlPkg::dataSrcSel got,
		input ctrlPkg::dataSrcSel expected);
		if (got !== expected) begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, expected);
			abortRun();
		end
	endtask

	// Fill every word, then lay the program over it
	task automatic loadMemory();
		for (int a = 0; a < 65536; a++) begin
			imem[a] = isaPkg::instrWord'(a) ^ FILL_MASK;
		end
		for (int r = 0; r < NUM_ROWS; r++) begin
			imem[VECTORS[r].addr] = VECTORS[r].word;
		end
	endtask

	// One LFSR step per stall bit
	task automatic nextStallBit(output logic bitOut);
		lfsrState = lfsrNext(lfsrState);
		bitOut = lfsrState[0];
	endtask

	task automatic checkResetState();
		checkFlag("decValid", decValid, 1'b0);
		checkFlag("halted", halted, 1'b0);
		checkFlag("regWrite", regWrite, 1'b0);
		checkFlag("memEnable", memEnable, 1'b0);
		checkFlag("memWrite", memWrite, 1'b0);
		checkFlag("aluSrcImm", aluSrcImm, 1'b0);
		checkFlag("branch", branch, 1'b0);
		checkFlag("branchSrc", branchSrc, 1'b0);
		checkDataSrc("dataSrc", dataSrc, ctrlPkg::DATA_ALU);
		checkPc("instrAddr", instrAddr, 16'h0000);
	endtask

	task automatic checkRow(input vecRow row);
		checkPc("decPc", decPc, row.addr);
		checkIndex("readReg1", readReg1, row.readReg1);
		checkIndex("readReg2", readReg2, row.readReg2);
		checkIndex("writeReg", writeReg, row.writeReg);
		checkWord("immValue", immValue, row.imm);
		checkCond("cond", cond, row.cond);
		checkFlag("regWrite", regWrite, row.ctrlBits[5]);
		checkFlag("memEnable", memEnable, row.ctrlBits[4]);
		checkFlag("memWrite", memWrite, row.ctrlBits[3]);
		checkFlag("aluSrcImm", aluSrcImm, row.ctrlBits[2]);
		checkFlag("branch", branch, row.ctrlBits[1]);
		checkFlag("branchSrc", branchSrc, row.ctrlBits[0]);
		checkDataSrc("dataSrc", dataSrc, row.dataSrc);
		checkFlag("halted", halted, row.halted);
	endtask

	// Halt must hold and the PC must stay just past the HLT
	task automatic watchHalt(input isaPkg::pcAddr frozenPc);
		logic stallBit;
		repeat (HALT_HOLD_CYCLES) begin
			@(negedge clk);
			nextStallBit(stallBit);
			stall = stallBit;
			checkFlag("halted", halted, 1'b1);
			checkPc("instrAddr", instrAddr, frozenPc);
		end
	endtask

	initial begin
		int row;
		logic stallBit;
		reset = 1'b1;
		stall = 1'b0;
		redirect = 1'b0;
		redirectPc = '0;
		lfsrState = LFSR_SEED;
		loadMemory();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		checkResetState();
		reset = 1'b0;

		row = 0;
		while (row < NUM_ROWS) begin
			@(negedge clk);
			// Redirect is a one-cycle pulse
			redirect = 1'b0;
			nextStallBit(stallBit);
			stall = stallBit;
			// A decode leaves the stage only at an edge with stall low
			if (decValid && !stallBit) begin
				checkRow(VECTORS[row]);
				if (VECTORS[row].action == HALT_JUMP) begin
					watchHalt(isaPkg::pcAddr'(VECTORS[row].addr + 16'd1));
				end
				if (VECTORS[row].action != STEP) begin
					redirect = 1'b1;
					redirectPc = VECTORS[row + 1].addr;
				end
				row++;
			end
		end

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+testbench
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/fetchDecodeIf.sv
logic/instrFetch.sv
logic/fetchDecodeBuffer.sv
logic/controlDecoder.sv
logic/instrDecode.sv
logic/decodeFrontEnd.sv
testbench/frontEndTb.sv

// File: Bender.yml
package:
  name: decode_front_end

sources:
  - files:
      - logic/isaPkg.sv
      - logic/ctrlPkg.sv
      - logic/fetchDecodeIf.sv
      - logic/instrFetch.sv
      - logic/fetchDecodeBuffer.sv
      - logic/controlDecoder.sv
      - logic/instrDecode.sv
      - logic/decodeFrontEnd.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/frontEndTb.sv
